// File: hdl/boot_pkg.sv
// Fixed 32-bit physical address and 64-bit data; config addresses must match the controller map
package boot_pkg;

   typedef logic [31:0] addr_t;
   typedef logic [63:0] data_t;

   // Only writes are issued on the boot path
   typedef enum logic {
      MEM_WR = 1'b0,
      MEM_RD = 1'b1
   } mem_op_e;

   // Shared by commands and responses
   typedef struct packed {
      mem_op_e op;
      addr_t   addr;
      data_t   data;
   } mem_msg_t;

   typedef enum logic [1:0] {
      NBF_WRITE  = 2'd0,
      NBF_FENCE  = 2'd1,
      NBF_FINISH = 2'd2
   } nbf_op_e;

   // One boot image record as delivered by the host
   typedef struct packed {
      nbf_op_e op;
      addr_t   addr;
      data_t   data;
   } nbf_rec_t;

   // Coherence controller configuration space
   localparam addr_t CFG_FREEZE_ADDR     = 32'h0020_0008;
   localparam addr_t CFG_CORE_ID_ADDR    = 32'h0020_0010;

   // Entry k of the instruction RAM sits at base + 8*k
   localparam addr_t CFG_INSTR_BASE_ADDR = 32'h0020_8000;

endpackage

// File: hdl/cfg_loader.sv
// Issues one config write at a time and needs exactly one in-order response per write
`timescale 1ns/1ps

module cfg_loader #(
   parameter int CORE_ID       = 0,
   parameter int INSTR_RAM_ELS = 8,
   parameter int SKIP_INIT     = 0
) (
   input  logic               clk_i,
   input  logic               rst_n_i,

   output boot_pkg::mem_msg_t cfg_cmd_o,
   output logic               cfg_cmd_v_o,
   input  logic               cfg_cmd_ready_i,

   input  boot_pkg::mem_msg_t cfg_resp_i,
   input  logic               cfg_resp_v_i,
   output logic               cfg_resp_ready_o,

   output logic               cfg_done_o
);
   import boot_pkg::*;

   // Freeze and core id, then the optional instruction RAM clear
   localparam int NUM_CMDS = 2 + ((SKIP_INIT != 0) ? 0 : INSTR_RAM_ELS);
   localparam int CNT_W    = $clog2(NUM_CMDS);

   typedef enum logic [1:0] {
      CFG_SEND,
      CFG_WAIT_RESP,
      CFG_DONE
   } cfg_state_e;

   cfg_state_e       state_r;
   logic [CNT_W-1:0] entry_cnt_r;
   logic [CNT_W-1:0] ram_idx;
   logic             last_entry;
   addr_t            cmd_addr;
   data_t            cmd_data;

   assign ram_idx    = entry_cnt_r - CNT_W'(2);
   assign last_entry = (entry_cnt_r == CNT_W'(NUM_CMDS - 1));

   always_comb
   begin
      if (entry_cnt_r == '0)
      begin
         cmd_addr = CFG_FREEZE_ADDR;
         cmd_data = data_t'(1);
      end
      else if (entry_cnt_r == CNT_W'(1))
      begin
         cmd_addr = CFG_CORE_ID_ADDR;
         cmd_data = data_t'(CORE_ID);
      end
      else
      begin
         cmd_addr = CFG_INSTR_BASE_ADDR + (addr_t'(ram_idx) << 3);
         cmd_data = '0;
      end
   end

   assign cfg_cmd_o        = '{op: MEM_WR, addr: cmd_addr, data: cmd_data};
   assign cfg_cmd_v_o      = (state_r == CFG_SEND);
   assign cfg_resp_ready_o = (state_r == CFG_WAIT_RESP);
   assign cfg_done_o       = (state_r == CFG_DONE);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_r     <= CFG_SEND;
         entry_cnt_r <= '0;
      end
      else
      begin
         case (state_r)
            CFG_SEND:
            begin
               if (cfg_cmd_ready_i)
                  state_r <= CFG_WAIT_RESP;
            end
            CFG_WAIT_RESP:
            begin
               if (cfg_resp_v_i)
               begin
                  if (last_entry)
                     state_r <= CFG_DONE;
                  else
                  begin
                     state_r     <= CFG_SEND;
                     entry_cnt_r <= entry_cnt_r + CNT_W'(1);
                  end
               end
            end
            default:
               state_r <= CFG_DONE;
         endcase
      end
   end

   // A response is only legal for the single write in flight
   a_resp_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cfg_resp_v_i |-> (state_r == CFG_WAIT_RESP));

endmodule

// File: hdl/nbf_loader.sv
// Holds one record at a time; responses must come back one per write, data is not inspected
`timescale 1ns/1ps

module nbf_loader #(
   parameter int MAX_OUTSTANDING = 4
) (
   input  logic               clk_i,
   input  logic               rst_n_i,

   input  boot_pkg::nbf_rec_t nbf_rec_i,
   input  logic               nbf_v_i,
   output logic               nbf_ready_o,

   output boot_pkg::mem_msg_t nbf_cmd_o,
   output logic               nbf_cmd_v_o,
   input  logic               nbf_cmd_ready_i,

   input  boot_pkg::mem_msg_t nbf_resp_i,
   input  logic               nbf_resp_v_i,
   output logic               nbf_resp_ready_o,

   output logic               nbf_done_o
);
   import boot_pkg::*;

   localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

   nbf_rec_t         rec_r;
   logic             rec_v_r;
   logic [CNT_W-1:0] cnt_r;
   logic             done_r;

   logic             rec_fire;
   logic             cmd_fire;
   logic             resp_fire;
   logic             cnt_zero;
   logic             cnt_full;
   logic             sync_retire;

   assign cnt_zero = (cnt_r == '0);
   assign cnt_full = (cnt_r == CNT_W'(MAX_OUTSTANDING));

   // Take a record only while the command port is granted and open
   assign nbf_ready_o = !rec_v_r && !done_r && nbf_cmd_ready_i;
   assign rec_fire    = nbf_v_i && nbf_ready_o;

   assign nbf_cmd_o   = '{op: MEM_WR, addr: rec_r.addr, data: rec_r.data};
   assign nbf_cmd_v_o = rec_v_r && (rec_r.op == NBF_WRITE) && !cnt_full;
   assign cmd_fire    = nbf_cmd_v_o && nbf_cmd_ready_i;

   assign nbf_resp_ready_o = 1'b1;
   assign resp_fire        = nbf_resp_v_i;

   // Fence and finish drain every write before retiring
   assign sync_retire = rec_v_r && (rec_r.op != NBF_WRITE) && cnt_zero;

   assign nbf_done_o = done_r;

   always_ff @(posedge clk_i)
   begin
      if (rec_fire)
         rec_r <= nbf_rec_i;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rec_v_r <= 1'b0;
         cnt_r   <= '0;
         done_r  <= 1'b0;
      end
      else
      begin
         if (rec_fire)
            rec_v_r <= 1'b1;
         else if (cmd_fire || sync_retire)
            rec_v_r <= 1'b0;

         if (sync_retire && (rec_r.op == NBF_FINISH))
            done_r <= 1'b1;

         if (cmd_fire && !resp_fire)
            cnt_r <= cnt_r + CNT_W'(1);
         else if (resp_fire && !cmd_fire)
            cnt_r <= cnt_r - CNT_W'(1);
      end
   end

   a_cnt_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cnt_r <= CNT_W'(MAX_OUTSTANDING));

   // Responses trail the io port, so none can come back with nothing in flight
   a_cnt_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      nbf_resp_v_i |-> !cnt_zero);

endmodule

// File: hdl/load_arbiter.sv
// Config side owns the port until cfg_done_i; assumes no config command is in flight at the switch
`timescale 1ns/1ps

module load_arbiter (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               cfg_done_i,

   input  boot_pkg::mem_msg_t cfg_cmd_i,
   input  logic               cfg_cmd_v_i,
   output logic               cfg_cmd_ready_o,
   output boot_pkg::mem_msg_t cfg_resp_o,
   output logic               cfg_resp_v_o,
   input  logic               cfg_resp_ready_i,

   input  boot_pkg::mem_msg_t nbf_cmd_i,
   input  logic               nbf_cmd_v_i,
   output logic               nbf_cmd_ready_o,
   output boot_pkg::mem_msg_t nbf_resp_o,
   output logic               nbf_resp_v_o,
   input  logic               nbf_resp_ready_i,

   output boot_pkg::mem_msg_t io_cmd_o,
   output logic               io_cmd_v_o,
   input  logic               io_cmd_ready_i,
   input  boot_pkg::mem_msg_t io_resp_i,
   input  logic               io_resp_v_i,
   output logic               io_resp_ready_o
);
   import boot_pkg::*;

   mem_msg_t hold_r;
   logic     hold_v_r;
   logic     hold_ready;
   mem_msg_t sel_cmd;
   logic     sel_v;
   logic     hold_load;

   assign hold_ready = !hold_v_r || io_cmd_ready_i;

   assign sel_cmd = cfg_done_i ? nbf_cmd_i : cfg_cmd_i;
   assign sel_v   = cfg_done_i ? nbf_cmd_v_i : cfg_cmd_v_i;

   assign cfg_cmd_ready_o = !cfg_done_i && hold_ready;
   assign nbf_cmd_ready_o = cfg_done_i && hold_ready;

   assign hold_load = sel_v && hold_ready;

   always_ff @(posedge clk_i)
   begin
      if (hold_load)
         hold_r <= sel_cmd;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         hold_v_r <= 1'b0;
      else if (hold_ready)
         hold_v_r <= sel_v;
   end

   assign io_cmd_o   = hold_r;
   assign io_cmd_v_o = hold_v_r;

   // Responses follow the same selection as commands
   assign cfg_resp_o      = io_resp_i;
   assign nbf_resp_o      = io_resp_i;
   assign cfg_resp_v_o    = !cfg_done_i && io_resp_v_i;
   assign nbf_resp_v_o    = cfg_done_i && io_resp_v_i;
   assign io_resp_ready_o = cfg_done_i ? nbf_resp_ready_i : cfg_resp_ready_i;

   a_io_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (io_cmd_v_o && !io_cmd_ready_i) |=> (io_cmd_v_o && $stable(io_cmd_o)));

endmodule

// File: hdl/boot_loader_top.sv
// One host command port; every io command must get exactly one response, in order
`timescale 1ns/1ps

module boot_loader_top #(
   parameter int CORE_ID         = 0,
   parameter int INSTR_RAM_ELS   = 8,
   parameter int SKIP_INIT       = 0,
   parameter int MAX_OUTSTANDING = 4
) (
   input  logic               clk_i,
   input  logic               rst_n_i,

   input  boot_pkg::nbf_rec_t nbf_rec_i,
   input  logic               nbf_v_i,
   output logic               nbf_ready_o,

   output boot_pkg::mem_msg_t io_cmd_o,
   output logic               io_cmd_v_o,
   input  logic               io_cmd_ready_i,

   input  boot_pkg::mem_msg_t io_resp_i,
   input  logic               io_resp_v_i,
   output logic               io_resp_ready_o,

   output logic               done_o
);
   import boot_pkg::*;

   mem_msg_t cfg_cmd;
   logic     cfg_cmd_v;
   logic     cfg_cmd_ready;
   mem_msg_t cfg_resp;
   logic     cfg_resp_v;
   logic     cfg_resp_ready;
   logic     cfg_done;

   mem_msg_t nbf_cmd;
   logic     nbf_cmd_v;
   logic     nbf_cmd_ready;
   mem_msg_t nbf_resp;
   logic     nbf_resp_v;
   logic     nbf_resp_ready;
   logic     nbf_done;

   cfg_loader #(
      .CORE_ID       (CORE_ID),
      .INSTR_RAM_ELS (INSTR_RAM_ELS),
      .SKIP_INIT     (SKIP_INIT)
   ) i_cfg_loader (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .cfg_cmd_o        (cfg_cmd),
      .cfg_cmd_v_o      (cfg_cmd_v),
      .cfg_cmd_ready_i  (cfg_cmd_ready),
      .cfg_resp_i       (cfg_resp),
      .cfg_resp_v_i     (cfg_resp_v),
      .cfg_resp_ready_o (cfg_resp_ready),
      .cfg_done_o       (cfg_done)
   );

   nbf_loader #(
      .MAX_OUTSTANDING (MAX_OUTSTANDING)
   ) i_nbf_loader (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .nbf_rec_i        (nbf_rec_i),
      .nbf_v_i          (nbf_v_i),
      .nbf_ready_o      (nbf_ready_o),
      .nbf_cmd_o        (nbf_cmd),
      .nbf_cmd_v_o      (nbf_cmd_v),
      .nbf_cmd_ready_i  (nbf_cmd_ready),
      .nbf_resp_i       (nbf_resp),
      .nbf_resp_v_i     (nbf_resp_v),
      .nbf_resp_ready_o (nbf_resp_ready),
      .nbf_done_o       (nbf_done)
   );

   load_arbiter i_load_arbiter (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .cfg_done_i       (cfg_done),
      .cfg_cmd_i        (cfg_cmd),
      .cfg_cmd_v_i      (cfg_cmd_v),
      .cfg_cmd_ready_o  (cfg_cmd_ready),
      .cfg_resp_o       (cfg_resp),
      .cfg_resp_v_o     (cfg_resp_v),
      .cfg_resp_ready_i (cfg_resp_ready),
      .nbf_cmd_i        (nbf_cmd),
      .nbf_cmd_v_i      (nbf_cmd_v),
      .nbf_cmd_ready_o  (nbf_cmd_ready),
      .nbf_resp_o       (nbf_resp),
      .nbf_resp_v_o     (nbf_resp_v),
      .nbf_resp_ready_i (nbf_resp_ready),
      .io_cmd_o         (io_cmd_o),
      .io_cmd_v_o       (io_cmd_v_o),
      .io_cmd_ready_i   (io_cmd_ready_i),
      .io_resp_i        (io_resp_i),
      .io_resp_v_i      (io_resp_v_i),
      .io_resp_ready_o  (io_resp_ready_o)
   );

   // Both done flags are sticky until reset
   assign done_o = cfg_done && nbf_done;

endmodule

// File: verif/boot_tb_table.svh
// Image records in issue order; fence and finish rows carry zero in the expected columns

// Record opcode, address and data, then the io address and data that a write must produce
typedef struct packed {
   nbf_op_e op;
   addr_t   addr;
   data_t   data;
   addr_t   exp_addr;
   data_t   exp_data;
} tb_row_t;

localparam int NUM_ROWS = 16;

tb_row_t table_rows [NUM_ROWS] = '{
   '{NBF_WRITE,  32'h8000_0000, 64'h0000_0297_0000_0013, 32'h8000_0000, 64'h0000_0297_0000_0013},
   '{NBF_WRITE,  32'h8000_0008, 64'h0182_8293_0000_0517, 32'h8000_0008, 64'h0182_8293_0000_0517},
   '{NBF_WRITE,  32'h8000_0010, 64'h1234_5678_9abc_def0, 32'h8000_0010, 64'h1234_5678_9abc_def0},
   '{NBF_WRITE,  32'h8000_0018, 64'hffff_0000_ffff_0000, 32'h8000_0018, 64'hffff_0000_ffff_0000},
   '{NBF_WRITE,  32'h8000_0020, 64'h0000_0000_dead_beef, 32'h8000_0020, 64'h0000_0000_dead_beef},
   '{NBF_FENCE,  32'h0000_0000, 64'h0,                   32'h0000_0000, 64'h0},
   '{NBF_WRITE,  32'h8000_1000, 64'ha5a5_a5a5_5a5a_5a5a, 32'h8000_1000, 64'ha5a5_a5a5_5a5a_5a5a},
   '{NBF_WRITE,  32'h8000_1008, 64'h0101_0202_0303_0404, 32'h8000_1008, 64'h0101_0202_0303_0404},
   '{NBF_WRITE,  32'h8000_1010, 64'h8000_0000_0000_0001, 32'h8000_1010, 64'h8000_0000_0000_0001},
   '{NBF_WRITE,  32'h8000_1018, 64'h0000_0000_0000_0000, 32'h8000_1018, 64'h0000_0000_0000_0000},
   '{NBF_FENCE,  32'h0000_0000, 64'h0,                   32'h0000_0000, 64'h0},
   '{NBF_WRITE,  32'h8000_2000, 64'hcafe_f00d_0bad_c0de, 32'h8000_2000, 64'hcafe_f00d_0bad_c0de},
   '{NBF_WRITE,  32'h8000_2008, 64'h7654_3210_fedc_ba98, 32'h8000_2008, 64'h7654_3210_fedc_ba98},
   '{NBF_WRITE,  32'h8000_2010, 64'h0000_ffff_0000_ffff, 32'h8000_2010, 64'h0000_ffff_0000_ffff},
   // The image releases the cores by clearing freeze
   '{NBF_WRITE,  CFG_FREEZE_ADDR, 64'h0,                 CFG_FREEZE_ADDR, 64'h0},
   '{NBF_FINISH, 32'h0000_0000, 64'h0,                   32'h0000_0000, 64'h0}
};

// File: verif/boot_loader_tb.sv
// Default parameter set only; the memory side answers in order after 0 to 5 cycles
`timescale 1ns/1ps

module boot_loader_tb;
   import boot_pkg::*;

   localparam int CORE_ID         = 0;
   localparam int INSTR_RAM_ELS   = 8;
   localparam int SKIP_INIT       = 0;
   localparam int MAX_OUTSTANDING = 4;
   localparam int CLK_PERIOD      = 20;
   localparam int RESET_CYCLES    = 8;
   localparam int N_CFG           = 2 + ((SKIP_INIT != 0) ? 0 : INSTR_RAM_ELS);

`include "boot_tb_table.svh"

   localparam int TIMEOUT_NS = (RESET_CYCLES + (N_CFG + NUM_ROWS) * 12) * CLK_PERIOD;

   logic     clk_i = 1'b0;
   logic     rst_n_i;
   nbf_rec_t nbf_rec_i;
   logic     nbf_v_i;
   logic     nbf_ready_o;
   mem_msg_t io_cmd_o;
   logic     io_cmd_v_o;
   logic     io_cmd_ready_i;
   mem_msg_t io_resp_i;
   logic     io_resp_v_i;
   logic     io_resp_ready_o;
   logic     done_o;

   // Expected io command stream with the config writes ahead of the image writes
   addr_t    exp_addr_q [$];
   data_t    exp_data_q [$];
   bit       exp_fence_q [$];

   int       cmd_cnt     = 0;
   int       resp_cnt    = 0;
   bit       finish_seen = 1'b0;
   bit       done_seen   = 1'b0;

   boot_loader_top #(
      .CORE_ID         (CORE_ID),
      .INSTR_RAM_ELS   (INSTR_RAM_ELS),
      .SKIP_INIT       (SKIP_INIT),
      .MAX_OUTSTANDING (MAX_OUTSTANDING)
   ) i_boot_loader_top (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .nbf_rec_i       (nbf_rec_i),
      .nbf_v_i         (nbf_v_i),
      .nbf_ready_o     (nbf_ready_o),
      .io_cmd_o        (io_cmd_o),
      .io_cmd_v_o      (io_cmd_v_o),
      .io_cmd_ready_i  (io_cmd_ready_i),
      .io_resp_i       (io_resp_i),
      .io_resp_v_i     (io_resp_v_i),
      .io_resp_ready_o (io_resp_ready_o),
      .done_o          (done_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_error(input string what);
      $display("ERROR: %s", what);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic expect_cmd(input addr_t addr, input data_t data, input bit after_fence);
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(data);
      exp_fence_q.push_back(after_fence);
   endtask

   task automatic build_expected();
      bit after_fence;
      after_fence = 1'b0;
      expect_cmd(CFG_FREEZE_ADDR, data_t'(1), 1'b0);
      expect_cmd(CFG_CORE_ID_ADDR, data_t'(CORE_ID), 1'b0);
      if (SKIP_INIT == 0)
      begin
         for (int k = 0; k < INSTR_RAM_ELS; k++)
            expect_cmd(CFG_INSTR_BASE_ADDR + addr_t'(k * 8), '0, 1'b0);
      end
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         if (table_rows[i].op == NBF_FENCE)
            after_fence = 1'b1;
         else if (table_rows[i].op == NBF_WRITE)
         begin
            expect_cmd(table_rows[i].exp_addr, table_rows[i].exp_data, after_fence);
            after_fence = 1'b0;
         end
      end
   endtask

   task automatic check_quiet_outputs();
      assert (io_cmd_v_o == 1'b0) else report_mismatch("io_cmd_v_o", io_cmd_v_o, 0);
      assert (nbf_ready_o == 1'b0) else report_mismatch("nbf_ready_o", nbf_ready_o, 0);
      assert (done_o == 1'b0) else report_mismatch("done_o", done_o, 0);
   endtask

   task automatic send_records();
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         nbf_rec_i <= '{op: table_rows[i].op, addr: table_rows[i].addr,
                        data: table_rows[i].data};
         nbf_v_i   <= 1'b1;
         @(posedge clk_i);
         while (!nbf_ready_o)
            @(posedge clk_i);
      end
      nbf_v_i <= 1'b0;
   endtask

   task automatic check_io_cmd();
      int idx;
      idx = cmd_cnt;
      assert (idx < exp_addr_q.size()) else report_error("io command beyond the expected stream");
      assert (io_cmd_o.op == MEM_WR) else report_mismatch("io_cmd_o.op", io_cmd_o.op, MEM_WR);
      assert (io_cmd_o.addr == exp_addr_q[idx])
         else report_mismatch("io_cmd_o.addr", io_cmd_o.addr, exp_addr_q[idx]);
      assert (io_cmd_o.data == exp_data_q[idx])
         else report_mismatch("io_cmd_o.data", io_cmd_o.data, exp_data_q[idx]);
      // A fence drains every earlier write before the next one may go out
      if (exp_fence_q[idx])
      begin
         assert (cmd_cnt == resp_cnt)
            else report_mismatch("outstanding at post-fence write", cmd_cnt - resp_cnt, 0);
      end
      cmd_cnt++;
   endtask

   initial
   begin
      rst_n_i   = 1'b0;
      nbf_v_i   = 1'b0;
      nbf_rec_i = '0;
      build_expected();
      repeat (RESET_CYCLES)
      begin
         @(posedge clk_i);
         check_quiet_outputs();
      end
      rst_n_i <= 1'b1;
      @(posedge clk_i);
      check_quiet_outputs();
      send_records();
      while (!done_o)
         @(posedge clk_i);
      // Hold a while so the monitor sees the port stay quiet
      repeat (10)
         @(posedge clk_i);
      assert (cmd_cnt == exp_addr_q.size())
         else report_mismatch("io command count", cmd_cnt, exp_addr_q.size());
      assert (resp_cnt == cmd_cnt) else report_mismatch("io response count", resp_cnt, cmd_cnt);
      $display("PASS: all tests");
      $finish;
   end

   // Memory responder with random back-pressure and in-order delayed responses
   initial
   begin : responder
      mem_msg_t    pend_q [$];
      int unsigned due_q [$];
      int unsigned cyc;
      bit          resp_fire;
      void'($urandom(77));
      io_cmd_ready_i = 1'b0;
      io_resp_v_i    = 1'b0;
      io_resp_i      = '0;
      cyc            = 0;
      forever
      begin
         @(posedge clk_i);
         cyc++;
         if (!rst_n_i)
            io_cmd_ready_i <= 1'b0;
         else
         begin
            if (io_cmd_v_o && io_cmd_ready_i)
            begin
               pend_q.push_back(io_cmd_o);
               due_q.push_back(cyc + $urandom_range(5, 0));
            end
            resp_fire = io_resp_v_i && io_resp_ready_o;
            if (resp_fire)
            begin
               void'(pend_q.pop_front());
               void'(due_q.pop_front());
            end
            if (!io_resp_v_i || resp_fire)
            begin
               if ((pend_q.size() > 0) && (due_q[0] <= cyc))
               begin
                  io_resp_v_i <= 1'b1;
                  io_resp_i   <= pend_q[0];
               end
               else
                  io_resp_v_i <= 1'b0;
            end
            io_cmd_ready_i <= ($urandom_range(3, 0) != 0);
         end
      end
   end

   always @(posedge clk_i)
   begin
      if (rst_n_i)
      begin
         if (done_seen)
         begin
            assert (done_o == 1'b1) else report_mismatch("done_o", done_o, 1);
            assert (io_cmd_v_o == 1'b0) else report_mismatch("io_cmd_v_o", io_cmd_v_o, 0);
            assert (nbf_ready_o == 1'b0) else report_mismatch("nbf_ready_o", nbf_ready_o, 0);
         end
         if (done_o && !done_seen)
         begin
            assert (finish_seen) else report_error("done_o rose before the finish record");
            assert (cmd_cnt == exp_addr_q.size())
               else report_mismatch("io commands at done_o", cmd_cnt, exp_addr_q.size());
            assert (cmd_cnt == resp_cnt)
               else report_mismatch("unanswered commands at done_o", cmd_cnt - resp_cnt, 0);
            done_seen = 1'b1;
         end
         if (io_cmd_v_o && io_cmd_ready_i)
            check_io_cmd();
         // Every response answers a command that its loader is waiting on
         if (io_resp_v_i)
         begin
            assert (io_resp_ready_o == 1'b1)
               else report_mismatch("io_resp_ready_o", io_resp_ready_o, 1);
         end
         if (io_resp_v_i && io_resp_ready_o)
            resp_cnt++;
         assert (cmd_cnt - resp_cnt <= MAX_OUTSTANDING)
            else report_mismatch("outstanding commands", cmd_cnt - resp_cnt, MAX_OUTSTANDING);
         if (nbf_v_i && nbf_ready_o && (nbf_rec_i.op == NBF_FINISH))
            finish_seen = 1'b1;
      end
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("ERROR: timeout after %0d ns, done_o never rose", TIMEOUT_NS);
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: all.f
+incdir+verif
hdl/boot_pkg.sv
hdl/cfg_loader.sv
hdl/nbf_loader.sv
hdl/load_arbiter.sv
hdl/boot_loader_top.sv
verif/boot_loader_tb.sv
